// File: cc_compute_unit.f
+incdir+include
hw/cc_pkg.sv
hw/cc_fifo.sv
hw/cc_vertex_sequencer.sv
hw/cc_edge_list_fetch.sv
hw/cc_label_fetch.sv
hw/cc_cmd_arbiter.sv
hw/cc_label_reduce.sv
hw/cc_compute_unit.sv
bench/cc_compute_unit_assert.sv
bench/cc_compute_unit_tb.sv

// File: Bender.yml
package:
  name: cc_compute_unit

sources:
  - include_dirs:
      - include
    files:
      - hw/cc_pkg.sv
      - hw/cc_fifo.sv
      - hw/cc_vertex_sequencer.sv
      - hw/cc_edge_list_fetch.sv
      - hw/cc_label_fetch.sv
      - hw/cc_cmd_arbiter.sv
      - hw/cc_label_reduce.sv
      - hw/cc_compute_unit.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - bench/cc_compute_unit_assert.sv
      - bench/cc_compute_unit_tb.sv

// File: bench/cc_compute_unit_tb.sv
// Compute unit testbench
`timescale 1ns/1ns
`default_nettype none

`include "cc_consts.svh"

module cc_compute_unit_tb
	import cc_pkg::*;
();

	localparam int          num_jobs        = 40;
	localparam int          watchdog_cycles = num_jobs * 10 * 40;
	localparam logic [31:0] seed            = 32'd78036;

	logic                    clock = 1'b0;
	logic                    rstn;
	logic                    job_valid;
	logic [`CC_VERTEX_W-1:0] job_id;
	logic [`CC_ADDR_W-1:0]   job_edge_start;
	logic [`CC_DEGREE_W-1:0] job_degree;
	logic                    job_request;
	logic                    cmd_request;
	logic                    cmd_grant;
	logic                    cmd_valid;
	cc_tag_t                 cmd_tag;
	logic [`CC_ADDR_W-1:0]   cmd_addr;
	logic [`CC_COUNT_W-1:0]  cmd_count;
	logic                    resp_valid;
	cc_tag_t                 resp_tag;
	logic [`CC_COUNT_W-1:0]  resp_count;
	logic [`CC_DATA_W-1:0]   resp_data;
	logic                    result_valid;
	logic [`CC_VERTEX_W-1:0] result_id;
	logic [`CC_VERTEX_W-1:0] result_label;
	logic [`CC_VERTEX_W-1:0] vertex_count;
	logic [`CC_ADDR_W-1:0]   edge_count;

	logic [31:0] job_rng;
	logic [31:0] resp_rng;
	int          errors       = 0;
	int          results_seen = 0;
	int          degree_sum   = 0;
	int          grant_count  = 0;
	int          strobe_count = 0;
	int          cycle        = 0;

	// Expected traffic, in the order the DUT must produce it
	logic [31:0] exp_edge_addr[$];
	logic [2:0]  exp_edge_count[$];
	logic [15:0] exp_label_addr[$];
	logic [15:0] exp_result_id[$];
	logic [15:0] exp_result_label[$];

	// Commands waiting for their read response
	cc_tag_t     pend_tag[$];
	logic [31:0] pend_addr[$];
	logic [2:0]  pend_count[$];
	int          pend_due[$];

	cc_compute_unit UUT (.*);

	always #2 clock = ~clock;

	////////////////////////////////////////////////////////////
	// Random numbers and graph memory model
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Neighbour id stored at an edge index
	function automatic logic [15:0] neighbour_of(input logic [31:0] edge_index);
		logic [31:0] h;
		h = xorshift32(xorshift32(edge_index ^ 32'h9e37_79b9));
		return 16'(h % 64);
	endfunction

	function automatic logic [15:0] label_of(input logic [15:0] vertex);
		logic [31:0] h;
		h = xorshift32(xorshift32({16'h5a17, vertex}));
		return h[15:0];
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Fail %s: expected %0h, actual %0h", name, expected, actual);
			errors++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Job driver with expected values
	////////////////////////////////////////////////////////////

	task automatic send_job(input int id);
		logic [31:0] start;
		logic [15:0] nb;
		logic [15:0] min_label;
		int          degree;
		int          off;
		job_rng = xorshift32(job_rng);
		degree = int'(job_rng % 10);
		job_rng = xorshift32(job_rng);
		start = job_rng & 32'h00ff_ffff;
		min_label = 16'hffff;
		// One edge-list line per four edges
		for (off = 0; off < degree; off += 4) begin
			exp_edge_addr.push_back(start + off);
			exp_edge_count.push_back((degree - off >= 4) ? 3'd4 : 3'(degree - off));
		end
		for (off = 0; off < degree; off++) begin
			nb = neighbour_of(start + off);
			exp_label_addr.push_back(nb);
			if (label_of(nb) < min_label) begin
				min_label = label_of(nb);
			end
		end
		if (degree > 0) begin
			exp_result_id.push_back(16'(id));
			exp_result_label.push_back(min_label);
		end
		degree_sum += degree;
		job_valid      <= 1'b1;
		job_id         <= 16'(id);
		job_edge_start <= start;
		job_degree     <= 16'(degree);
	endtask

	////////////////////////////////////////////////////////////
	// Memory responder and command checks
	////////////////////////////////////////////////////////////

	task automatic check_command();
		if (cmd_tag == TAG_EDGE_LIST) begin
			if (exp_edge_addr.size() == 0) begin
				$display("Edge-list read at %0h arrived with none expected", cmd_addr);
				errors++;
			end else begin
				check_value("edge list address", exp_edge_addr.pop_front(), cmd_addr);
				check_value("edge list count", exp_edge_count.pop_front(), cmd_count);
			end
		end else if (exp_label_addr.size() == 0) begin
			$display("Label read at %0h arrived with none expected", cmd_addr);
			errors++;
		end else begin
			check_value("label address", exp_label_addr.pop_front(), cmd_addr);
			check_value("label count", 1, cmd_count);
		end
	endtask

	task automatic send_response();
		logic [63:0] data;
		logic [31:0] addr;
		logic [2:0]  count;
		cc_tag_t     tag;
		int          lane;
		tag   = pend_tag.pop_front();
		addr  = pend_addr.pop_front();
		count = pend_count.pop_front();
		void'(pend_due.pop_front());
		// Unused lanes carry junk
		data = {resp_rng, xorshift32(resp_rng)};
		if (tag == TAG_LABEL) begin
			data[15:0] = label_of(addr[15:0]);
		end else begin
			for (lane = 0; lane < count; lane++) begin
				data[lane*16 +: 16] = neighbour_of(addr + lane);
			end
		end
		resp_valid <= 1'b1;
		resp_tag   <= tag;
		resp_count <= count;
		resp_data  <= data;
	endtask

	always @(posedge clock) begin
		if (rstn) begin
			resp_rng = xorshift32(resp_rng);
			cmd_grant <= (resp_rng[2:0] < 3'd5);
			if (cmd_grant && cmd_request) begin
				grant_count++;
			end
			if (cmd_valid) begin
				strobe_count++;
				check_command();
				pend_tag.push_back(cmd_tag);
				pend_addr.push_back(cmd_addr);
				pend_count.push_back(cmd_count);
				pend_due.push_back(cycle + 1 + int'(resp_rng[10:8]));
			end
			resp_valid <= 1'b0;
			// In order, head of line blocks
			if (pend_due.size() > 0 && cycle >= pend_due[0]) begin
				send_response();
			end
			cycle++;
		end
	end

	always @(posedge clock) begin
		if (rstn && result_valid) begin
			results_seen++;
			if (exp_result_id.size() == 0) begin
				$display("Result for vertex %0d arrived with no vertex left", result_id);
				errors++;
			end else begin
				check_value("result id", exp_result_id.pop_front(), result_id);
				check_value("result label", exp_result_label.pop_front(), result_label);
			end
		end
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clock);
		$display("Timeout after %0d cycles, the jobs did not all finish", watchdog_cycles);
		$display("Simulation finished: FAIL");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		int sent;
		int burst;
		int total;
		rstn           = 1'b0;
		job_valid      = 1'b0;
		job_id         = '0;
		job_edge_start = '0;
		job_degree     = '0;
		cmd_grant      = 1'b0;
		resp_valid     = 1'b0;
		resp_tag       = TAG_EDGE_LIST;
		resp_count     = '0;
		resp_data      = '0;
		job_rng        = seed;
		resp_rng       = xorshift32(seed);
		sent           = 0;
		repeat (8) @(posedge clock);
		rstn <= 1'b1;
		// Empty job buffer asks for work one cycle after release
		repeat (2) @(posedge clock);
		check_value("job request after reset", 1, job_request);
		while (sent < num_jobs) begin
			@(posedge clock);
			if (job_request) begin
				job_rng = xorshift32(job_rng);
				burst = 1 + int'(job_rng % 4);
				while (burst > 0 && sent < num_jobs) begin
					send_job(sent);
					sent++;
					burst--;
					@(posedge clock);
				end
				job_valid <= 1'b0;
				// Let job_request catch up with the buffer
				repeat (3) @(posedge clock);
			end
		end
		// Drain until every expected result is in and memory is idle
		while (exp_result_id.size() != 0 || pend_due.size() != 0 || cmd_request) begin
			@(posedge clock);
		end
		// Degree-zero vertices still queued finish in a few cycles each
		repeat (4 * num_jobs) @(posedge clock);
		check_value("vertex count", num_jobs, vertex_count);
		check_value("edge count", degree_sum, edge_count);
		check_value("command strobes", grant_count, strobe_count);
		check_value("results outstanding", 0, exp_result_id.size());
		check_value("label reads outstanding", 0, exp_label_addr.size());
		total = errors + UUT.u_assert.failures;
		$display("Errors: %0d checks, %0d assertions, %0d results seen",
			errors, UUT.u_assert.failures, results_seen);
		if (total == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/cc_compute_unit_assert.sv
// Compute unit protocol assertions
`timescale 1ns/1ns
`default_nettype none

`include "cc_consts.svh"

module cc_compute_unit_assert (
	input wire logic                   clock,
	input wire logic                   rstn,
	input wire logic                   cmd_grant,
	input wire logic                   cmd_request,
	input wire logic                   cmd_valid,
	input wire logic [`CC_COUNT_W-1:0] cmd_count,
	input wire logic                   result_valid,
	input wire logic                   job_request
);

	int failures = 0;

	// Command strobe only after a grant that found work
	cmd_after_grant: assert property (@(posedge clock) disable iff (!rstn)
		cmd_valid |-> $past(cmd_grant && cmd_request))
		else begin
			$error("cmd_valid without an effective grant one cycle earlier");
			failures++;
		end

	cmd_count_nonzero: assert property (@(posedge clock) disable iff (!rstn)
		cmd_valid |-> (cmd_count != '0))
		else begin
			$error("cmd_count is zero on a command strobe");
			failures++;
		end

	result_single: assert property (@(posedge clock) disable iff (!rstn)
		result_valid |=> !result_valid)
		else begin
			$error("result_valid high for two cycles in a row");
			failures++;
		end

	no_request_in_reset: assert property (@(posedge clock) !rstn |-> !job_request)
		else begin
			$error("job_request high during reset");
			failures++;
		end

endmodule

bind cc_compute_unit cc_compute_unit_assert u_assert (
	.clock        (clock),
	.rstn         (rstn),
	.cmd_grant    (cmd_grant),
	.cmd_request  (cmd_request),
	.cmd_valid    (cmd_valid),
	.cmd_count    (cmd_count),
	.result_valid (result_valid),
	.job_request  (job_request)
);

`default_nettype wire

// File: hw/cc_compute_unit.sv
// Connected-components compute unit
`timescale 1ns/1ns
`default_nettype none

`include "cc_consts.svh"

module cc_compute_unit
	import cc_pkg::*;
(
	input  wire logic                    clock,
	input  wire logic                    rstn,
	input  wire logic                    job_valid,
	input  wire logic [`CC_VERTEX_W-1:0] job_id,
	input  wire logic [`CC_ADDR_W-1:0]   job_edge_start,
	input  wire logic [`CC_DEGREE_W-1:0] job_degree,
	output logic                         job_request,
	output logic                         cmd_request,
	input  wire logic                    cmd_grant,
	output logic                         cmd_valid,
	output cc_tag_t                      cmd_tag,
	output logic [`CC_ADDR_W-1:0]        cmd_addr,
	output logic [`CC_COUNT_W-1:0]       cmd_count,
	input  wire logic                    resp_valid,
	input  wire cc_tag_t                 resp_tag,
	input  wire logic [`CC_COUNT_W-1:0]  resp_count,
	input  wire logic [`CC_DATA_W-1:0]   resp_data,
	output logic                         result_valid,
	output logic [`CC_VERTEX_W-1:0]      result_id,
	output logic [`CC_VERTEX_W-1:0]      result_label,
	output logic [`CC_VERTEX_W-1:0]      vertex_count,
	output logic [`CC_ADDR_W-1:0]        edge_count
);

	cc_vertex_job_t job;
	cc_vertex_job_t cur_job;
	cc_read_resp_t  resp;
	cc_read_cmd_t   src_cmd0;
	cc_read_cmd_t   src_cmd1;
	cc_read_cmd_t   cmd;
	logic           cur_valid;
	logic           vertex_done;
	logic [1:0]     src_valid;
	logic [1:0]     src_taken;

	assign job       = '{id: job_id, edge_start: job_edge_start, degree: job_degree};
	assign resp      = '{tag: resp_tag, count: resp_count, data: resp_data};
	assign cmd_tag   = cmd.tag;
	assign cmd_addr  = cmd.addr;
	assign cmd_count = cmd.count;

	////////////////////////////////////////////////////////////
	// Vertex jobs
	////////////////////////////////////////////////////////////

	cc_vertex_sequencer u_sequencer (
		.clock       (clock),
		.rstn        (rstn),
		.job_valid   (job_valid),
		.job         (job),
		.vertex_done (vertex_done),
		.job_request (job_request),
		.cur_valid   (cur_valid),
		.cur_job     (cur_job)
	);

	////////////////////////////////////////////////////////////
	// Command sources, edge list on port 0
	////////////////////////////////////////////////////////////

	cc_edge_list_fetch u_edge_list_fetch (
		.clock     (clock),
		.rstn      (rstn),
		.cur_valid (cur_valid),
		.cur_job   (cur_job),
		.src_taken (src_taken[0]),
		.src_valid (src_valid[0]),
		.src_cmd   (src_cmd0)
	);

	cc_label_fetch u_label_fetch (
		.clock      (clock),
		.rstn       (rstn),
		.resp_valid (resp_valid),
		.resp       (resp),
		.src_taken  (src_taken[1]),
		.src_valid  (src_valid[1]),
		.src_cmd    (src_cmd1)
	);

	cc_cmd_arbiter u_cmd_arbiter (
		.clock       (clock),
		.rstn        (rstn),
		.src_valid   (src_valid),
		.src_cmd0    (src_cmd0),
		.src_cmd1    (src_cmd1),
		.src_taken   (src_taken),
		.cmd_grant   (cmd_grant),
		.cmd_request (cmd_request),
		.cmd_valid   (cmd_valid),
		.cmd         (cmd)
	);

	////////////////////////////////////////////////////////////
	// Label reduction
	////////////////////////////////////////////////////////////

	cc_label_reduce u_label_reduce (
		.clock        (clock),
		.rstn         (rstn),
		.resp_valid   (resp_valid),
		.resp         (resp),
		.cur_valid    (cur_valid),
		.cur_job      (cur_job),
		.vertex_done  (vertex_done),
		.result_valid (result_valid),
		.result_id    (result_id),
		.result_label (result_label),
		.vertex_count (vertex_count),
		.edge_count   (edge_count)
	);

endmodule

`default_nettype wire

// File: hw/cc_label_reduce.sv
// Minimum label reduction and counters
`timescale 1ns/1ns
`default_nettype none

`include "cc_consts.svh"

module cc_label_reduce
	import cc_pkg::*;
(
	input  wire logic           clock,
	input  wire logic           rstn,
	input  wire logic           resp_valid,
	input  wire cc_read_resp_t  resp,
	input  wire logic           cur_valid,
	input  wire cc_vertex_job_t cur_job,
	output logic                vertex_done,
	output logic                result_valid,
	output logic [`CC_VERTEX_W-1:0] result_id,
	output logic [`CC_VERTEX_W-1:0] result_label,
	output logic [`CC_VERTEX_W-1:0] vertex_count,
	output logic [`CC_ADDR_W-1:0]   edge_count
);

	logic [`CC_VERTEX_W-1:0] label;
	logic [`CC_VERTEX_W-1:0] min_label;
	logic [`CC_VERTEX_W-1:0] next_min;
	logic [`CC_DEGREE_W-1:0] seen;
	logic                    label_hit;
	logic                    last_edge;
	logic                    empty_vertex;

	assign label_hit = resp_valid && (resp.tag == TAG_LABEL);
	assign label     = resp.data[`CC_VERTEX_W-1:0];
	assign next_min  = (label < min_label) ? label : min_label;
	assign last_edge = label_hit && ((seen + 1'b1) == cur_job.degree);

	// Degree zero finishes at once, guarded so it fires only once
	assign empty_vertex = cur_valid && (cur_job.degree == '0) && !vertex_done;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_done  <= 1'b0;
			result_valid <= 1'b0;
			seen         <= '0;
			min_label    <= '1;
			vertex_count <= '0;
			edge_count   <= '0;
		end else begin
			vertex_done  <= last_edge || empty_vertex;
			result_valid <= last_edge;
			if (label_hit) begin
				edge_count <= edge_count + 1'b1;
			end
			if (last_edge || empty_vertex) begin
				vertex_count <= vertex_count + 1'b1;
			end
			if (last_edge) begin
				seen      <= '0;
				min_label <= '1;
			end else if (label_hit) begin
				seen      <= seen + 1'b1;
				min_label <= next_min;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (last_edge) begin
			result_id    <= cur_job.id;
			result_label <= next_min;
		end
	end

endmodule

`default_nettype wire

// File: hw/cc_cmd_arbiter.sv
// Read command arbiter and burst buffer
`timescale 1ns/1ns
`default_nettype none

`include "cc_consts.svh"

module cc_cmd_arbiter
	import cc_pkg::*;
(
	input  wire logic         clock,
	input  wire logic         rstn,
	input  wire logic [1:0]   src_valid,
	input  wire cc_read_cmd_t src_cmd0,
	input  wire cc_read_cmd_t src_cmd1,
	output logic [1:0]        src_taken,
	input  wire logic         cmd_grant,
	output logic              cmd_request,
	output logic              cmd_valid,
	output cc_read_cmd_t      cmd
);

	cc_read_cmd_t chosen;
	cc_read_cmd_t head_cmd;
	logic         win;
	logic         last_win;
	logic         push;
	logic         pop;
	logic         buf_empty;
	logic         buf_almost_full;

	////////////////////////////////////////////////////////////
	// Round-robin choice
	////////////////////////////////////////////////////////////

	// Both pending means the loser of last round goes first
	always_comb begin
		if (src_valid == 2'b11) begin
			win = ~last_win;
		end else begin
			win = src_valid[1];
		end
	end

	assign chosen    = win ? src_cmd1 : src_cmd0;
	assign push      = (|src_valid) && !buf_almost_full;
	assign src_taken = push ? {win, ~win} : 2'b00;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			last_win <= 1'b0;
		end else if (push) begin
			last_win <= win;
		end
	end

	////////////////////////////////////////////////////////////
	// Burst command buffer and bus handshake
	////////////////////////////////////////////////////////////

	cc_fifo #(
		.payload_t (cc_read_cmd_t),
		.depth     (`CC_CMD_FIFO_DEPTH)
	) u_cmd_fifo (
		.clock       (clock),
		.rstn        (rstn),
		.push        (push),
		.data_in     (chosen),
		.pop         (pop),
		.data_out    (head_cmd),
		.empty       (buf_empty),
		.almost_full (buf_almost_full)
	);

	assign cmd_request = !buf_empty;
	// Stray grants are dropped
	assign pop = cmd_grant && !buf_empty;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cmd_valid <= 1'b0;
		end else begin
			cmd_valid <= pop;
		end
	end

	always_ff @(posedge clock) begin
		if (pop) begin
			cmd <= head_cmd;
		end
	end

endmodule

`default_nettype wire

// File: hw/cc_label_fetch.sv
// Neighbour label read command generator
`timescale 1ns/1ns
`default_nettype none

`include "cc_consts.svh"

module cc_label_fetch
	import cc_pkg::*;
(
	input  wire logic          clock,
	input  wire logic          rstn,
	input  wire logic          resp_valid,
	input  wire cc_read_resp_t resp,
	input  wire logic          src_taken,
	output logic               src_valid,
	output cc_read_cmd_t       src_cmd
);

	localparam int lane_w = $clog2(`CC_EDGES_PER_LINE);

	cc_edge_line_t     line_in;
	cc_edge_line_t     line_head;
	logic              line_push;
	logic              line_pop;
	logic              line_empty;
	logic [lane_w-1:0] lane;
	logic              last_lane;

	// Edge-list responses only
	assign line_push     = resp_valid && (resp.tag == TAG_EDGE_LIST);
	assign line_in.count = resp.count;
	assign line_in.data  = resp.data;

	cc_fifo #(
		.payload_t (cc_edge_line_t),
		.depth     (`CC_LINE_FIFO_DEPTH)
	) u_line_fifo (
		.clock       (clock),
		.rstn        (rstn),
		.push        (line_push),
		.data_in     (line_in),
		.pop         (line_pop),
		.data_out    (line_head),
		.empty       (line_empty),
		.almost_full ()
	);

	assign last_lane = ((`CC_COUNT_W'(lane) + 1'b1) == line_head.count);
	assign line_pop  = src_taken && last_lane;
	assign src_valid = !line_empty;

	// One label read per neighbour id, lane 0 first
	always_comb begin
		src_cmd.tag   = TAG_LABEL;
		src_cmd.addr  = `CC_ADDR_W'(line_head.data[lane*`CC_VERTEX_W +: `CC_VERTEX_W]);
		src_cmd.count = `CC_COUNT_W'(1);
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			lane <= '0;
		end else if (src_taken) begin
			lane <= last_lane ? '0 : lane + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: hw/cc_edge_list_fetch.sv
// Edge-list read command generator
`timescale 1ns/1ns
`default_nettype none

`include "cc_consts.svh"

module cc_edge_list_fetch
	import cc_pkg::*;
(
	input  wire logic           clock,
	input  wire logic           rstn,
	input  wire logic           cur_valid,
	input  wire cc_vertex_job_t cur_job,
	input  wire logic           src_taken,
	output logic                src_valid,
	output cc_read_cmd_t        src_cmd
);

	logic [`CC_DEGREE_W-1:0] offset;
	logic [`CC_DEGREE_W-1:0] remaining;
	logic [`CC_COUNT_W-1:0]  next_count;
	logic                    list_done;
	logic                    load;

	assign remaining  = cur_job.degree - offset;
	assign next_count = (remaining >= `CC_DEGREE_W'(`CC_EDGES_PER_LINE)) ?
		`CC_COUNT_W'(`CC_EDGES_PER_LINE) : remaining[`CC_COUNT_W-1:0];

	// Next slot opens in the same cycle the pending command is taken
	assign load = cur_valid && !list_done && (!src_valid || src_taken);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			src_valid <= 1'b0;
			offset    <= '0;
			list_done <= 1'b0;
		end else if (!cur_valid) begin
			src_valid <= 1'b0;
			offset    <= '0;
			list_done <= 1'b0;
		end else if (load) begin
			if (remaining == '0) begin
				src_valid <= 1'b0;
				list_done <= 1'b1;
			end else begin
				src_valid <= 1'b1;
				offset    <= offset + `CC_DEGREE_W'(next_count);
			end
		end
	end

	always_ff @(posedge clock) begin
		if (load) begin
			src_cmd.tag   <= TAG_EDGE_LIST;
			src_cmd.addr  <= cur_job.edge_start + `CC_ADDR_W'(offset);
			src_cmd.count <= next_count;
		end
	end

endmodule

`default_nettype wire

// File: hw/cc_vertex_sequencer.sv
// Vertex job sequencer
`timescale 1ns/1ns
`default_nettype none

`include "cc_consts.svh"

module cc_vertex_sequencer
	import cc_pkg::*;
(
	input  wire logic           clock,
	input  wire logic           rstn,
	input  wire logic           job_valid,
	input  wire cc_vertex_job_t job,
	input  wire logic           vertex_done,
	output logic                job_request,
	output logic                cur_valid,
	output cc_vertex_job_t      cur_job
);

	cc_vertex_job_t head_job;
	logic           fifo_empty;
	logic           take_job;

	// Only one vertex in flight
	assign take_job = !cur_valid && !fifo_empty;

	cc_fifo #(
		.payload_t (cc_vertex_job_t),
		.depth     (`CC_VERTEX_FIFO_DEPTH)
	) u_job_fifo (
		.clock       (clock),
		.rstn        (rstn),
		.push        (job_valid),
		.data_in     (job),
		.pop         (take_job),
		.data_out    (head_job),
		.empty       (fifo_empty),
		.almost_full ()
	);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_request <= 1'b0;
			cur_valid   <= 1'b0;
		end else begin
			// Ask for more work while the buffer is dry
			job_request <= fifo_empty;
			if (take_job) begin
				cur_valid <= 1'b1;
			end else if (vertex_done) begin
				cur_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (take_job) begin
			cur_job <= head_job;
		end
	end

endmodule

`default_nettype wire

// File: hw/cc_fifo.sv
// Synchronous payload FIFO
`timescale 1ns/1ns
`default_nettype none

module cc_fifo #(
	parameter type payload_t = logic,
	parameter int  depth     = 4
) (
	input  wire logic     clock,
	input  wire logic     rstn,
	input  wire logic     push,
	input  wire payload_t data_in,
	input  wire logic     pop,
	output payload_t      data_out,
	output logic          empty,
	output logic          almost_full
);

	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_w = $clog2(depth + 1);

	payload_t         mem [depth];
	logic [ptr_w-1:0] rd_ptr;
	logic [ptr_w-1:0] wr_ptr;
	logic [cnt_w-1:0] fill;

	// Head is read straight from storage
	assign data_out    = mem[rd_ptr];
	assign empty       = (fill == '0);
	assign almost_full = (fill >= cnt_w'(depth - 1));

	always_ff @(posedge clock) begin
		if (push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			fill   <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hw/cc_pkg.sv
// Compute unit types
`default_nettype none

`include "cc_consts.svh"

package cc_pkg;

	// Array type of a read, used to route responses
	typedef enum logic {
		TAG_EDGE_LIST = 1'b0,
		TAG_LABEL     = 1'b1
	} cc_tag_t;

	typedef struct packed {
		logic [`CC_VERTEX_W-1:0] id;
		logic [`CC_ADDR_W-1:0]   edge_start;
		logic [`CC_DEGREE_W-1:0] degree;
	} cc_vertex_job_t;

	// Count is 1 to 4 lanes
	typedef struct packed {
		cc_tag_t                tag;
		logic [`CC_ADDR_W-1:0]  addr;
		logic [`CC_COUNT_W-1:0] count;
	} cc_read_cmd_t;

	typedef struct packed {
		cc_tag_t                tag;
		logic [`CC_COUNT_W-1:0] count;
		logic [`CC_DATA_W-1:0]  data;
	} cc_read_resp_t;

	typedef struct packed {
		logic [`CC_COUNT_W-1:0] count;
		logic [`CC_DATA_W-1:0]  data;
	} cc_edge_line_t;

endpackage

`default_nettype wire

// File: include/cc_consts.svh
// Compute unit constants
`ifndef CC_CONSTS_SVH
`define CC_CONSTS_SVH

// Vertex id and label width
`define CC_VERTEX_W 16
// Edge index and read address width
`define CC_ADDR_W 32
`define CC_DEGREE_W 16

// Neighbour ids per edge-list line, and lane count field
`define CC_EDGES_PER_LINE 4
`define CC_COUNT_W 3

// Read data, 4 lanes of 16 bits
`define CC_DATA_W 64

// Buffer depths
`define CC_VERTEX_FIFO_DEPTH 16
`define CC_CMD_FIFO_DEPTH 8
`define CC_LINE_FIFO_DEPTH 4

`endif
